// ==== Makefile ====
# Verilator build and run for the multicycle RV32I core testbench
VERILATOR ?= verilator
TOP       ?= rv32Tb
FILELIST  ?= vlog.f
OBJ_DIR   ?= obj_dir
LOG       ?= sim.log
VFLAGS    ?= --binary --timing
PASS_TEXT ?= Done: no errors

SOURCES := $(wildcard design/*.sv design/*.svh sim/*.sv)

.PHONY: all compile run clean

all: run

compile: $(OBJ_DIR)/V$(TOP)

$(OBJ_DIR)/V$(TOP): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) --Mdir $(OBJ_DIR) -f $(FILELIST)

run: compile
	./$(OBJ_DIR)/V$(TOP) > $(LOG) 2>&1; cat $(LOG)
	@if grep -qF "$(PASS_TEXT)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed"; \
		exit 1; \
	fi

clean:
	rm -rf $(OBJ_DIR) $(LOG)

// ==== design/aluUnit.sv ====
/* ALU of the multicycle core with its own operation decoder;
   the FSM gives the class, funct3 and funct7 bit 5 pick the function */
`timescale 1ns/100ps
`include "rv32_defines.svh"

module aluUnit (
	input  logic [`XLEN-1:0] srcA,
	input  logic [`XLEN-1:0] srcB,
	input  rv32Pkg::aluOp_t  aluOp,
	input  logic [2:0]       funct3,
	input  logic             funct7b5,
	output logic [`XLEN-1:0] result,
	output logic             zero
);

	typedef enum logic [2:0] {
		FN_ADD, FN_SUB, FN_AND, FN_OR, FN_XOR, FN_SLT, FN_SLL, FN_SRL
	} aluFunc_t;

	aluFunc_t aluFunc;

	// operation decoder
	always_comb begin
		aluFunc = FN_ADD;
		case (aluOp)
			rv32Pkg::ALU_OP_ADD: aluFunc = FN_ADD;
			rv32Pkg::ALU_OP_SUB: aluFunc = FN_SUB;
			default: begin
				case (funct3)
					// sub only for R-type, addi has no funct7
					3'b000: begin
						if (aluOp == rv32Pkg::ALU_OP_RTYPE && funct7b5) begin
							aluFunc = FN_SUB;
						end else begin
							aluFunc = FN_ADD;
						end
					end
					3'b001:  aluFunc = FN_SLL;
					3'b010:  aluFunc = FN_SLT;
					3'b100:  aluFunc = FN_XOR;
					3'b101:  aluFunc = FN_SRL;
					3'b110:  aluFunc = FN_OR;
					3'b111:  aluFunc = FN_AND;
					default: aluFunc = FN_ADD;
				endcase
			end
		endcase
	end

	always_comb begin
		case (aluFunc)
			FN_SUB:  result = srcA - srcB;
			FN_AND:  result = srcA & srcB;
			FN_OR:   result = srcA | srcB;
			FN_XOR:  result = srcA ^ srcB;
			FN_SLT:  result = `XLEN'($signed(srcA) < $signed(srcB));
			FN_SLL:  result = srcA << srcB[4:0];
			FN_SRL:  result = srcA >> srcB[4:0];
			default: result = srcA + srcB;
		endcase
	end

	assign zero = (result == '0);

endmodule

// ==== design/controlFsm.sv ====
/* Moore control FSM of the multicycle core; steps each instruction through
   fetch, decode, execute, memory and writeback and drives the datapath selects */
`timescale 1ns/100ps

module controlFsm (
	input  logic                clk,
	input  logic                reset,
	input  rv32Pkg::opcode_t    opcode,
	input  logic                zeroFlag,
	output rv32Pkg::adrSrc_t    adrSrc,
	output logic                irWrite,
	output logic                regWrite,
	output logic                pcUpdate,
	output rv32Pkg::pcSrc_t     pcSrc,
	output logic                memWrite,
	output rv32Pkg::aluSrcA_t   aluSrcA,
	output rv32Pkg::aluSrcB_t   aluSrcB,
	output rv32Pkg::aluOp_t     aluOp,
	output rv32Pkg::resultSrc_t resultSrc
);

	rv32Pkg::fsmState_t state;
	rv32Pkg::fsmState_t nextState;

	always_ff @(posedge clk) begin
		if (reset) begin
			state <= rv32Pkg::FETCH;
		end else begin
			state <= nextState;
		end
	end

	// next state
	always_comb begin
		nextState = rv32Pkg::FETCH;
		case (state)
			rv32Pkg::FETCH: nextState = rv32Pkg::DECODE;
			rv32Pkg::DECODE: begin
				case (opcode)
					rv32Pkg::RType:      nextState = rv32Pkg::EXECUTER;
					rv32Pkg::ITypeLogic: nextState = rv32Pkg::EXECUTEI;
					rv32Pkg::ITypeLoad:  nextState = rv32Pkg::MEMADR;
					rv32Pkg::SType:      nextState = rv32Pkg::MEMADR;
					rv32Pkg::BType:      nextState = rv32Pkg::BRANCHIFEQ;
					rv32Pkg::JType:      nextState = rv32Pkg::UNCONDJUMP;
					rv32Pkg::UTypeLui:   nextState = rv32Pkg::LUI;
					rv32Pkg::UTypeAuipc: nextState = rv32Pkg::AUIPC;
					// unknown opcode goes straight back to fetch
					default:             nextState = rv32Pkg::FETCH;
				endcase
			end
			rv32Pkg::MEMADR: begin
				if (opcode == rv32Pkg::ITypeLoad) begin
					nextState = rv32Pkg::MEMREAD;
				end else begin
					nextState = rv32Pkg::MEMWRITE;
				end
			end
			rv32Pkg::EXECUTER:   nextState = rv32Pkg::ALUWB;
			rv32Pkg::EXECUTEI:   nextState = rv32Pkg::ALUWB;
			rv32Pkg::UNCONDJUMP: nextState = rv32Pkg::ALUWB;
			rv32Pkg::LUI:        nextState = rv32Pkg::ALUWB;
			rv32Pkg::AUIPC:      nextState = rv32Pkg::ALUWB;
			rv32Pkg::MEMREAD:    nextState = rv32Pkg::MEMWB;
			default:             nextState = rv32Pkg::FETCH;
		endcase
	end

	// datapath controls decoded from the state
	always_comb begin
		adrSrc    = rv32Pkg::ADR_PC;
		irWrite   = 1'b0;
		regWrite  = 1'b0;
		pcUpdate  = 1'b0;
		pcSrc     = rv32Pkg::PC_PLUS4;
		memWrite  = 1'b0;
		aluSrcA   = rv32Pkg::ALU_SRC_A_REG;
		aluSrcB   = rv32Pkg::ALU_SRC_B_REG;
		aluOp     = rv32Pkg::ALU_OP_ADD;
		resultSrc = rv32Pkg::RESULT_ALU_OUT;
		case (state)
			rv32Pkg::FETCH: begin
				irWrite  = 1'b1;
				pcUpdate = 1'b1;
			end
			// old PC plus immediate gives the branch or jump target and the auipc result
			rv32Pkg::DECODE, rv32Pkg::AUIPC: begin
				aluSrcA = rv32Pkg::ALU_SRC_A_OLD_PC;
				aluSrcB = rv32Pkg::ALU_SRC_B_IMM;
			end
			rv32Pkg::LUI: begin
				aluSrcA = rv32Pkg::ALU_SRC_A_ZERO;
				aluSrcB = rv32Pkg::ALU_SRC_B_IMM;
			end
			rv32Pkg::EXECUTER: begin
				aluOp = rv32Pkg::ALU_OP_RTYPE;
			end
			rv32Pkg::EXECUTEI: begin
				aluSrcB = rv32Pkg::ALU_SRC_B_IMM;
				aluOp   = rv32Pkg::ALU_OP_ITYPE;
			end
			rv32Pkg::MEMADR: begin
				aluSrcB = rv32Pkg::ALU_SRC_B_IMM;
			end
			// jump to the target while the link value is formed
			rv32Pkg::UNCONDJUMP: begin
				aluSrcA  = rv32Pkg::ALU_SRC_A_OLD_PC;
				aluSrcB  = rv32Pkg::ALU_SRC_B_FOUR;
				pcSrc    = rv32Pkg::PC_ALU_OUT;
				pcUpdate = 1'b1;
			end
			rv32Pkg::BRANCHIFEQ: begin
				aluOp    = rv32Pkg::ALU_OP_SUB;
				pcSrc    = rv32Pkg::PC_ALU_OUT;
				pcUpdate = zeroFlag;
			end
			rv32Pkg::MEMREAD: begin
				adrSrc = rv32Pkg::ADR_ALU_OUT;
			end
			rv32Pkg::MEMWRITE: begin
				adrSrc   = rv32Pkg::ADR_ALU_OUT;
				memWrite = 1'b1;
			end
			rv32Pkg::MEMWB: begin
				resultSrc = rv32Pkg::RESULT_DATA;
				regWrite  = 1'b1;
			end
			rv32Pkg::ALUWB: begin
				regWrite = 1'b1;
			end
		endcase
	end

endmodule

// ==== design/immExtend.sv ====
/* immediate generator; picks the I, S, B, J or U layout from the
   instruction's own opcode and sign-extends it to the data width */
`timescale 1ns/100ps
`include "rv32_defines.svh"

module immExtend (
	input  logic [`XLEN-1:0] instr,
	output logic [`XLEN-1:0] immExt
);

	rv32Pkg::opcode_t opcode;

	assign opcode = rv32Pkg::opcode_t'(instr[6:0]);

	always_comb begin
		case (opcode)
			rv32Pkg::ITypeLogic, rv32Pkg::ITypeLoad:
				immExt = {{20{instr[31]}}, instr[31:20]};
			rv32Pkg::SType:
				immExt = {{20{instr[31]}}, instr[31:25], instr[11:7]};
			// byte offsets, bit 0 always zero
			rv32Pkg::BType:
				immExt = {{20{instr[31]}}, instr[7], instr[30:25], instr[11:8], 1'b0};
			rv32Pkg::JType:
				immExt = {{12{instr[31]}}, instr[19:12], instr[20], instr[30:21], 1'b0};
			rv32Pkg::UTypeLui, rv32Pkg::UTypeAuipc:
				immExt = {instr[31:12], 12'b0};
			// R-type and unknown opcodes carry no immediate
			default:
				immExt = '0;
		endcase
	end

endmodule

// ==== design/registerFile.sv ====
/* 32-entry integer register file; two combinational read ports and one
   write port on the clock edge, x0 hardwired to zero */
`timescale 1ns/100ps
`include "rv32_defines.svh"

module registerFile (
	input  logic             clk,
	input  logic             reset,
	input  logic [4:0]       readAddr1,
	input  logic [4:0]       readAddr2,
	input  logic [4:0]       writeAddr,
	input  logic [`XLEN-1:0] writeData,
	input  logic             writeEnable,
	output logic [`XLEN-1:0] readData1,
	output logic [`XLEN-1:0] readData2
);

	logic [`XLEN-1:0] regs [`REG_COUNT];

	always_ff @(posedge clk) begin
		if (reset) begin
			for (int i = 0; i < `REG_COUNT; i++) begin
				regs[i] <= '0;
			end
		end else if (writeEnable && writeAddr != 5'd0) begin
			regs[writeAddr] <= writeData;
		end
	end

	// x0 reads zero
	assign readData1 = (readAddr1 == 5'd0) ? '0 : regs[readAddr1];
	assign readData2 = (readAddr2 == 5'd0) ? '0 : regs[readAddr2];

endmodule

// ==== design/rv32Multicycle.sv ====
/* top level of the multicycle RV32I core; holds the datapath registers and
   muxes and shares one memory port between fetch, loads and stores */
`timescale 1ns/100ps
`include "rv32_defines.svh"

module rv32Multicycle (
	input  logic             clk,
	input  logic             reset,
	input  logic [`XLEN-1:0] memReadData,
	output logic [`XLEN-1:0] memAddr,
	output logic [`XLEN-1:0] memWriteData,
	output logic             memWrite
);

	// architectural and inter-cycle registers
	logic [`XLEN-1:0] pc;
	logic [`XLEN-1:0] oldPc;
	logic [`XLEN-1:0] instr;
	logic [`XLEN-1:0] dataReg;
	logic [`XLEN-1:0] regA;
	logic [`XLEN-1:0] regB;
	logic [`XLEN-1:0] aluOut;

	logic [`XLEN-1:0] pcPlus4;
	logic [`XLEN-1:0] pcNext;
	logic [`XLEN-1:0] immExt;
	logic [`XLEN-1:0] rfData1;
	logic [`XLEN-1:0] rfData2;
	logic [`XLEN-1:0] srcA;
	logic [`XLEN-1:0] srcB;
	logic [`XLEN-1:0] aluResult;
	logic [`XLEN-1:0] result;
	logic             aluZero;

	rv32Pkg::opcode_t    opcode;
	rv32Pkg::adrSrc_t    adrSrc;
	rv32Pkg::pcSrc_t     pcSrc;
	rv32Pkg::aluSrcA_t   aluSrcA;
	rv32Pkg::aluSrcB_t   aluSrcB;
	rv32Pkg::aluOp_t     aluOp;
	rv32Pkg::resultSrc_t resultSrc;
	logic                irWrite;
	logic                regWrite;
	logic                pcUpdate;

	assign opcode = rv32Pkg::opcode_t'(instr[6:0]);

	controlFsm u_controlFsm (
		.clk       (clk),
		.reset     (reset),
		.opcode    (opcode),
		.zeroFlag  (aluZero),
		.adrSrc    (adrSrc),
		.irWrite   (irWrite),
		.regWrite  (regWrite),
		.pcUpdate  (pcUpdate),
		.pcSrc     (pcSrc),
		.memWrite  (memWrite),
		.aluSrcA   (aluSrcA),
		.aluSrcB   (aluSrcB),
		.aluOp     (aluOp),
		.resultSrc (resultSrc)
	);

	// dedicated incrementer, keeps the ALU free during fetch
	assign pcPlus4 = pc + `XLEN'(4);
	assign pcNext  = (pcSrc == rv32Pkg::PC_ALU_OUT) ? aluOut : pcPlus4;

	always_ff @(posedge clk) begin
		if (reset) begin
			pc <= `RESET_PC;
		end else if (pcUpdate) begin
			pc <= pcNext;
		end
	end

	always_ff @(posedge clk) begin
		if (irWrite) begin
			instr <= memReadData;
			oldPc <= pc;
		end
	end

	// these capture every cycle
	always_ff @(posedge clk) begin
		dataReg <= memReadData;
		regA    <= rfData1;
		regB    <= rfData2;
		aluOut  <= aluResult;
	end

	registerFile u_registerFile (
		.clk         (clk),
		.reset       (reset),
		.readAddr1   (instr[19:15]),
		.readAddr2   (instr[24:20]),
		.writeAddr   (instr[11:7]),
		.writeData   (result),
		.writeEnable (regWrite),
		.readData1   (rfData1),
		.readData2   (rfData2)
	);

	immExtend u_immExtend (
		.instr  (instr),
		.immExt (immExt)
	);

	// operand muxes
	always_comb begin
		case (aluSrcA)
			rv32Pkg::ALU_SRC_A_OLD_PC: srcA = oldPc;
			rv32Pkg::ALU_SRC_A_ZERO:   srcA = '0;
			default:                   srcA = regA;
		endcase
		case (aluSrcB)
			rv32Pkg::ALU_SRC_B_IMM:  srcB = immExt;
			rv32Pkg::ALU_SRC_B_FOUR: srcB = `XLEN'(4);
			default:                 srcB = regB;
		endcase
	end

	aluUnit u_aluUnit (
		.srcA     (srcA),
		.srcB     (srcB),
		.aluOp    (aluOp),
		.funct3   (instr[14:12]),
		.funct7b5 (instr[30]),
		.result   (aluResult),
		.zero     (aluZero)
	);

	assign result = (resultSrc == rv32Pkg::RESULT_DATA) ? dataReg : aluOut;

	// shared memory port
	assign memAddr      = (adrSrc == rv32Pkg::ADR_ALU_OUT) ? aluOut : pc;
	assign memWriteData = regB;

endmodule

// ==== design/rv32Pkg.sv ====
/* shared types for the multicycle RV32I core: opcodes, FSM states
   and the datapath select encodings driven by the control FSM */
package rv32Pkg;

	// RV32I major opcodes handled by the core
	typedef enum logic [6:0] {
		RType      = 7'b0110011,
		ITypeLogic = 7'b0010011,
		ITypeLoad  = 7'b0000011,
		SType      = 7'b0100011,
		BType      = 7'b1100011,
		JType      = 7'b1101111,
		UTypeLui   = 7'b0110111,
		UTypeAuipc = 7'b0010111
	} opcode_t;

	// control FSM states, FETCH first so it is the zero encoding
	typedef enum logic [3:0] {
		FETCH,
		DECODE,
		EXECUTER,
		EXECUTEI,
		UNCONDJUMP,
		LUI,
		AUIPC,
		MEMADR,
		MEMREAD,
		MEMWRITE,
		MEMWB,
		ALUWB,
		BRANCHIFEQ
	} fsmState_t;

	// ALU operation class, refined by funct3 inside the ALU
	typedef enum logic [1:0] {
		ALU_OP_ADD   = 2'b00,
		ALU_OP_SUB   = 2'b01,
		ALU_OP_RTYPE = 2'b10,
		ALU_OP_ITYPE = 2'b11
	} aluOp_t;

	typedef enum logic [1:0] {ALU_SRC_A_REG, ALU_SRC_A_OLD_PC, ALU_SRC_A_ZERO} aluSrcA_t;

	typedef enum logic [1:0] {ALU_SRC_B_REG, ALU_SRC_B_IMM, ALU_SRC_B_FOUR} aluSrcB_t;

	typedef enum logic {RESULT_ALU_OUT, RESULT_DATA} resultSrc_t;

	typedef enum logic {ADR_PC, ADR_ALU_OUT} adrSrc_t;

	// next PC when pcUpdate is high
	typedef enum logic {PC_PLUS4, PC_ALU_OUT} pcSrc_t;

endpackage

// ==== design/rv32_defines.svh ====
/* core-wide widths and the reset vector for the multicycle RV32I core;
   include wherever a port or register width depends on them */
`ifndef RV32_DEFINES_SVH
`define RV32_DEFINES_SVH

// data and address width
`define XLEN 32

// architectural registers x0 to x31
`define REG_COUNT 32

// first fetch address after reset
`define RESET_PC 32'h0000_0000

`endif

// ==== sim/rv32Tb.sv ====
/* directed testbench for the multicycle RV32I core; models a 1K-word memory,
   loads small programs into it and checks every store the core makes */
`timescale 1ns/100ps
`include "rv32_defines.svh"

module rv32Tb;

	localparam int WAIT_LIMIT = 500;
	localparam logic [6:0] OP_R = 7'b0110011;
	localparam logic [6:0] OP_IMM = 7'b0010011;

	logic             clk;
	logic             reset;
	logic [`XLEN-1:0] memReadData;
	logic [`XLEN-1:0] memAddr;
	logic [`XLEN-1:0] memWriteData;
	logic             memWrite;

	logic [`XLEN-1:0] mem [1024];
	logic [`XLEN-1:0] storeAddrs [$];
	logic [`XLEN-1:0] storeData [$];
	int               progPtr;
	int               errorCount;
	int               checkCount;

	rv32Multicycle u_rv32Multicycle (
		.clk          (clk),
		.reset        (reset),
		.memReadData  (memReadData),
		.memAddr      (memAddr),
		.memWriteData (memWriteData),
		.memWrite     (memWrite)
	);

	initial begin
		clk = 1'b0;
		forever #10 clk = ~clk;
	end

	// word-addressed memory, combinational read
	assign memReadData = mem[memAddr[11:2]];

	always @(posedge clk) begin
		if (memWrite) begin
			mem[memAddr[11:2]] <= memWriteData;
		end
	end

	// stores logged mid-cycle while the port is stable
	always @(negedge clk) begin
		if (!reset && memWrite) begin
			storeAddrs.push_back(memAddr);
			storeData.push_back(memWriteData);
		end
	end

	function automatic logic [31:0] encI(logic [11:0] imm, logic [4:0] rs1, logic [2:0] f3,
			logic [4:0] rd, logic [6:0] op);
		return {imm, rs1, f3, rd, op};
	endfunction

	// lw rd, off(x0)
	function automatic logic [31:0] encLw(logic [11:0] off, logic [4:0] rd);
		return {off, 5'd0, 3'b010, rd, 7'b0000011};
	endfunction

	// sw rs2, off(x0)
	function automatic logic [31:0] encSw(logic [11:0] off, logic [4:0] rs2);
		return {off[11:5], rs2, 5'd0, 3'b010, off[4:0], 7'b0100011};
	endfunction

	function automatic logic [31:0] encBeq(logic [12:0] off, logic [4:0] rs1, logic [4:0] rs2);
		return {off[12], off[10:5], rs2, rs1, 3'b000, off[4:1], off[11], 7'b1100011};
	endfunction

	function automatic logic [31:0] encJal(logic [20:0] off, logic [4:0] rd);
		return {off[20], off[10:1], off[11], off[19:12], rd, 7'b1101111};
	endfunction

	function automatic logic [31:0] sext(logic [11:0] imm);
		return {{20{imm[11]}}, imm};
	endfunction

	// result area starts at byte 0x600
	function automatic logic [11:0] storeOff(int k);
		return 12'h600 + {k[9:0], 2'b00};
	endfunction

	// RV32I semantics for the funct3 codes under test
	function automatic logic [31:0] refAlu(logic [2:0] f3, logic isSub, logic [31:0] a,
			logic [31:0] b);
		case (f3)
			3'd0:    return isSub ? a - b : a + b;
			3'd1:    return a << b[4:0];
			3'd2:    return {31'd0, $signed(a) < $signed(b)};
			3'd4:    return a ^ b;
			3'd5:    return a >> b[4:0];
			3'd6:    return a | b;
			default: return a & b;
		endcase
	endfunction

	task automatic checkValue(input string testName, input logic [31:0] expected,
			input logic [31:0] actual);
		checkCount++;
		if (actual !== expected) begin
			$display("mismatch %s: expected %h, actual %h", testName, expected, actual);
			errorCount++;
		end
	endtask

	task automatic emit(input logic [31:0] word);
		mem[progPtr[9:0]] <= word;
		progPtr++;
	endtask

	task automatic resetAndClear();
		int i;
		@(negedge clk);
		reset = 1'b1;
		@(negedge clk);
		// unsupported opcodes everywhere, a runaway PC only skips
		for (i = 0; i < 1024; i++) begin
			mem[i[9:0]] <= {15'd0, i[9:0], 7'h7f};
		end
		storeAddrs.delete();
		storeData.delete();
		progPtr = int'(`RESET_PC >> 2);
	endtask

	task automatic startProgram();
		// halt loop, jal x0 to itself
		emit(encJal(21'd0, 5'd0));
		@(negedge clk);
		reset = 1'b0;
	endtask

	task automatic waitStores(input string testName, input int count);
		int cycles;
		cycles = 0;
		while (storeAddrs.size() < count && cycles < WAIT_LIMIT) begin
			@(negedge clk);
			cycles++;
		end
		if (storeAddrs.size() < count) begin
			$display("%s timed out with %0d of %0d stores after %0d cycles", testName,
				storeAddrs.size(), count, cycles);
			errorCount++;
		end
		// a stray store would show up here
		repeat (20) @(negedge clk);
		checkValue({testName, " store count"}, count, storeAddrs.size());
	endtask

	task automatic checkStore(input string testName, input int idx, input logic [31:0] expAddr,
			input logic [31:0] expData);
		if (idx < storeAddrs.size()) begin
			checkValue({testName, " addr"}, expAddr, storeAddrs[idx]);
			checkValue({testName, " data"}, expData, storeData[idx]);
		end else begin
			$display("%s: store %0d never appeared", testName, idx);
			errorCount++;
		end
	endtask

	task automatic testReset();
		int i;
		resetAndClear();
		startProgram();
		// first cycle out of reset fetches from the reset vector
		checkValue("reset fetch addr", `RESET_PC, memAddr);
		for (i = 0; i < 10; i++) begin
			checkValue("reset memWrite", 32'd0, {31'd0, memWrite});
			@(negedge clk);
		end
	endtask

	// R-type when isImm is low, I-type otherwise; in I mode slot 1 writes x0
	task automatic testArith(input logic isImm);
		logic [2:0]  f3List [8];
		logic        subList [8];
		logic [31:0] b [8];
		logic [31:0] a;
		logic [31:0] tmp;
		logic [31:0] expected;
		logic [11:0] imm;
		logic [4:0]  rd;
		string       name;
		int          k;
		f3List = '{3'd0, 3'd0, 3'd7, 3'd6, 3'd4, 3'd2, 3'd1, 3'd5};
		subList = '{1'b0, 1'b1, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0, 1'b0};
		a = $urandom();
		resetAndClear();
		mem[256] <= a;
		emit(encLw(12'h400, 5'd1));
		for (k = 0; k < 8; k++) begin
			tmp = $urandom();
			rd = (isImm && k == 1) ? 5'd0 : 5'd3;
			if (isImm) begin
				imm = (f3List[k] == 3'd1 || f3List[k] == 3'd5) ? {7'd0, tmp[4:0]} : tmp[11:0];
				// negative addi
				if (k == 0) begin
					imm[11] = 1'b1;
				end
				b[k] = sext(imm);
				emit(encI(imm, 5'd1, f3List[k], rd, OP_IMM));
			end else begin
				b[k] = tmp;
				mem[10'd257 + k[9:0]] <= tmp;
				emit(encLw(12'h404 + {k[9:0], 2'b00}, 5'd2));
				emit(encI({subList[k] ? 7'h20 : 7'h00, 5'd2}, 5'd1, f3List[k], rd, OP_R));
			end
			emit(encSw(storeOff(k), rd));
		end
		startProgram();
		waitStores(isImm ? "itype" : "rtype", 8);
		for (k = 0; k < 8; k++) begin
			name = $sformatf("%s f3=%0d sub=%0d", isImm ? "itype" : "rtype", f3List[k],
				subList[k]);
			expected = (isImm && k == 1) ? 32'd0 : refAlu(f3List[k], subList[k] && !isImm, a, b[k]);
			checkStore(name, k, {20'd0, storeOff(k)}, expected);
		end
	endtask

	task automatic testBranch();
		logic [31:0] a;
		a = $urandom();
		resetAndClear();
		mem[256] <= a;
		mem[257] <= a;
		mem[258] <= a ^ 32'd1;
		emit(encLw(12'h400, 5'd1));
		emit(encLw(12'h404, 5'd2));
		emit(encLw(12'h408, 5'd3));
		emit(encI(12'h011, 5'd0, 3'd0, 5'd5, OP_IMM));
		emit(encI(12'h022, 5'd0, 3'd0, 5'd6, OP_IMM));
		// taken, jumps over the next store
		emit(encBeq(13'd8, 5'd1, 5'd2));
		emit(encSw(storeOff(0), 5'd6));
		emit(encSw(storeOff(1), 5'd5));
		// not taken, both stores follow
		emit(encBeq(13'd8, 5'd1, 5'd3));
		emit(encSw(storeOff(2), 5'd6));
		emit(encSw(storeOff(3), 5'd5));
		startProgram();
		waitStores("beq", 3);
		checkStore("beq taken", 0, {20'd0, storeOff(1)}, 32'h11);
		checkStore("beq not taken", 1, {20'd0, storeOff(2)}, 32'h22);
		checkStore("beq fall through", 2, {20'd0, storeOff(3)}, 32'h11);
	endtask

	task automatic testJumpUpper();
		logic [31:0] tmp;
		logic [19:0] luiImm;
		logic [19:0] auipcImm;
		logic [31:0] jalPc;
		logic [31:0] auipcPc;
		tmp = $urandom();
		luiImm = tmp[19:0];
		tmp = $urandom();
		auipcImm = tmp[31:12];
		resetAndClear();
		jalPc = 32'(progPtr * 4);
		emit(encJal(21'd8, 5'd7));
		emit(encSw(storeOff(0), 5'd0));
		emit(encSw(storeOff(1), 5'd7));
		emit({luiImm, 5'd8, 7'b0110111});
		emit(encSw(storeOff(2), 5'd8));
		auipcPc = 32'(progPtr * 4);
		emit({auipcImm, 5'd9, 7'b0010111});
		emit(encSw(storeOff(3), 5'd9));
		startProgram();
		waitStores("jal lui auipc", 3);
		checkStore("jal link", 0, {20'd0, storeOff(1)}, jalPc + 32'd4);
		checkStore("lui", 1, {20'd0, storeOff(2)}, {luiImm, 12'd0});
		checkStore("auipc", 2, {20'd0, storeOff(3)}, auipcPc + {auipcImm, 12'd0});
	endtask

	task automatic testUnsupported();
		logic [31:0] tmp;
		tmp = $urandom();
		resetAndClear();
		emit(encI(tmp[11:0], 5'd0, 3'd0, 5'd10, OP_IMM));
		// custom-0 opcode naming x10 as rd, x10 must survive
		emit({12'h123, 5'd10, 3'd0, 5'd10, 7'b0001011});
		emit(encSw(storeOff(0), 5'd10));
		startProgram();
		waitStores("unsupported", 1);
		checkStore("unsupported skip", 0, {20'd0, storeOff(0)}, sext(tmp[11:0]));
	endtask

	initial begin
		reset = 1'b1;
		progPtr = 0;
		errorCount = 0;
		checkCount = 0;
		void'($urandom(64259));
		testReset();
		testArith(1'b0);
		testArith(1'b1);
		testBranch();
		testJumpUpper();
		testUnsupported();
		$display("%0d checks, %0d errors", checkCount, errorCount);
		if (errorCount == 0) begin
			$display("Done: no errors");
		end else begin
			$display("Done: errors found");
		end
		$finish;
	end

endmodule

// ==== vlog.f ====
+incdir+design
design/rv32Pkg.sv
design/controlFsm.sv
design/aluUnit.sv
design/immExtend.sv
design/registerFile.sv
design/rv32Multicycle.sv
sim/rv32Tb.sv
